// File: Makefile
SIM     = verilator
FLAGS   = --binary --timing -j 0
TOP     = tbMipsCore
FILELIST = vlog.f
OBJDIR  = obj_dir
BIN     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJDIR)

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::wordT    ifIdInstr,
    input  mipsPkg::wordT    ifIdPc,
    input  logic             idBubble,
    input  mipsPkg::regAddrT memDstReg,
    input  logic             memRegWrite,
    input  mipsPkg::wordT    memAluResult,
    input  logic             wbRegWrite,
    input  mipsPkg::regAddrT wbDstReg,
    input  mipsPkg::wordT    wbData,
    output logic             redirect,
    output mipsPkg::wordT    redirectPc,
    output mipsPkg::opcodeT  idOpcode,
    output mipsPkg::functT   idFunct,
    output mipsPkg::regAddrT idRs,
    output mipsPkg::regAddrT idRt,
    output mipsPkg::regAddrT exRs,
    output mipsPkg::regAddrT exRt,
    output mipsPkg::regAddrT exDstReg,
    output logic             exRegWrite,
    output logic             exMemRead,
    output logic             exMemWrite,
    output mipsPkg::aluOpT   exAluOp,
    output logic             exAluSrcImm,
    output mipsPkg::wordT    exA,
    output mipsPkg::wordT    exB,
    output mipsPkg::wordT    exImm,
    output logic             exLink,
    output mipsPkg::wordT    exLinkAddr
);
    import mipsPkg::*;

    wordT    regFile [32];
    wordT    rfRs, rfRt;     // Register file with write-through
    wordT    cmpRs, cmpRt;   // Branch compare operands
    wordT    pcPlus4, imm, branchPc;
    regAddrT rd, dstReg;
    regDstT  regDst;
    aluOpT   aluOp;
    logic    regWrite, memRead, memWrite, aluSrcImm, zeroExt;
    logic    isJump, isJr, link, taken;

    assign idOpcode = ifIdInstr[31:26];
    assign idRs     = ifIdInstr[25:21];
    assign idRt     = ifIdInstr[20:16];
    assign rd       = ifIdInstr[15:11];
    assign idFunct  = ifIdInstr[5:0];
    assign pcPlus4  = ifIdPc + 32'd4;

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        regDst    = REG_DST_RT;
        aluOp     = ALU_ADD;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        aluSrcImm = 1'b0;
        zeroExt   = 1'b0;
        isJump    = 1'b0;
        isJr      = 1'b0;
        link      = 1'b0;
        case (idOpcode)
            OP_RTYPE: begin
                regDst   = REG_DST_RD;
                regWrite = 1'b1;
                case (idFunct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_JR: begin
                        regWrite = 1'b0;
                        isJr     = 1'b1;
                    end
                    default: regWrite = 1'b0;   // Bubble and unknowns as no-op
                endcase
            end
            OP_ADDI: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            OP_ORI: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                zeroExt   = 1'b1;
                aluOp     = ALU_OR;
            end
            OP_LUI: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = ALU_LUI;
            end
            OP_LW: begin
                regWrite  = 1'b1;
                memRead   = 1'b1;
                aluSrcImm = 1'b1;
            end
            OP_SW: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;   // Address is rs + offset
            end
            OP_JAL: begin
                regWrite = 1'b1;
                regDst   = REG_DST_RA;
                link     = 1'b1;
                isJump   = 1'b1;
            end
            OP_J:    isJump = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (regDst)
            REG_DST_RD: dstReg = rd;
            REG_DST_RA: dstReg = 5'd31;
            default:    dstReg = idRt;
        endcase
    end

    assign imm = zeroExt ? {16'h0, ifIdInstr[15:0]} : {{16{ifIdInstr[15]}}, ifIdInstr[15:0]};

    // ------------------------------
    // Register file
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wbRegWrite && wbDstReg != '0)
            regFile[wbDstReg] <= wbData;   // r0 writes dropped
    end

    assign rfRs = (idRs == '0) ? '0 : (wbRegWrite && wbDstReg == idRs) ? wbData : regFile[idRs];
    assign rfRt = (idRt == '0) ? '0 : (wbRegWrite && wbDstReg == idRt) ? wbData : regFile[idRt];

    // MEM-stage forwarding for compare and JR only
    assign cmpRs = (memRegWrite && memDstReg != '0 && memDstReg == idRs) ? memAluResult : rfRs;
    assign cmpRt = (memRegWrite && memDstReg != '0 && memDstReg == idRt) ? memAluResult : rfRt;

    // Branch and jump resolution
    assign taken    = ((idOpcode == OP_BEQ) && (cmpRs == cmpRt))
                   || ((idOpcode == OP_BNE) && (cmpRs != cmpRt));
    assign branchPc = pcPlus4 + {imm[29:0], 2'b00};
    assign redirect = !idBubble && (taken || isJump || isJr);

    always_comb begin
        if (isJr)
            redirectPc = cmpRs;
        else if (isJump)
            redirectPc = {pcPlus4[31:28], ifIdInstr[25:0], 2'b00};
        else
            redirectPc = branchPc;
    end

    // ------------------------------
    // ID/EX register
    // ------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exDstReg   <= '0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exLink     <= 1'b0;
        end else begin
            exDstReg   <= dstReg;
            exRegWrite <= regWrite && !idBubble;   // Stall inserts a bubble
            exMemRead  <= memRead && !idBubble;
            exMemWrite <= memWrite && !idBubble;
            exLink     <= link && !idBubble;
        end
    end

    always_ff @(posedge clk) begin
        exRs        <= idRs;
        exRt        <= idRt;
        exAluOp     <= aluOp;
        exAluSrcImm <= aluSrcImm;
        exA         <= rfRs;
        exB         <= rfRt;
        exImm       <= imm;
        exLinkAddr  <= pcPlus4;   // No delay slot
    end

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::regAddrT exRs,
    input  mipsPkg::regAddrT exRt,
    input  mipsPkg::regAddrT exDstReg,
    input  logic             exRegWrite,
    input  logic             exMemRead,
    input  logic             exMemWrite,
    input  mipsPkg::aluOpT   exAluOp,
    input  logic             exAluSrcImm,
    input  mipsPkg::wordT    exA,
    input  mipsPkg::wordT    exB,
    input  mipsPkg::wordT    exImm,
    input  logic             exLink,
    input  mipsPkg::wordT    exLinkAddr,
    input  logic             wbRegWrite,
    input  mipsPkg::regAddrT wbDstReg,
    input  mipsPkg::wordT    wbData,
    output mipsPkg::regAddrT memDstReg,
    output logic             memRegWrite,
    output logic             memMemRead,
    output logic             memMemWrite,
    output mipsPkg::wordT    memAluResult,
    output mipsPkg::wordT    memStoreData
);
    import mipsPkg::*;

    wordT srcA, srcB, aluB, aluOut;

    // ------------------------------
    // Operand forwarding
    // ------------------------------
    always_comb begin
        if (memRegWrite && memDstReg != '0 && memDstReg == exRs)
            srcA = memAluResult;   // Newest value first
        else if (wbRegWrite && wbDstReg != '0 && wbDstReg == exRs)
            srcA = wbData;
        else
            srcA = exA;
        if (memRegWrite && memDstReg != '0 && memDstReg == exRt)
            srcB = memAluResult;
        else if (wbRegWrite && wbDstReg != '0 && wbDstReg == exRt)
            srcB = wbData;
        else
            srcB = exB;
    end

    assign aluB = exAluSrcImm ? exImm : srcB;

    always_comb begin
        case (exAluOp)
            ALU_SUB: aluOut = srcA - aluB;
            ALU_AND: aluOut = srcA & aluB;
            ALU_OR:  aluOut = srcA | aluB;
            ALU_SLT: aluOut = {31'h0, $signed(srcA) < $signed(aluB)};
            ALU_LUI: aluOut = {aluB[15:0], 16'h0};
            default: aluOut = srcA + aluB;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memDstReg   <= '0;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memDstReg   <= exDstReg;
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        memAluResult <= exLink ? exLinkAddr : aluOut;   // JAL writes PC + 4
        memStoreData <= srcB;
    end

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic          clk,
    input  logic          arstN,
    input  logic          imemWe,
    input  logic [7:0]    imemAddr,
    input  mipsPkg::wordT imemData,
    input  logic          pcWrite,
    input  logic          ifIdWrite,
    input  logic          redirect,
    input  mipsPkg::wordT redirectPc,
    output mipsPkg::wordT ifIdInstr,
    output mipsPkg::wordT ifIdPc
);
    import mipsPkg::*;

    wordT pc;
    wordT imem [IMEM_DEPTH];

    // Loader port, only while the core is held in reset
    always_ff @(posedge clk) begin
        if (!arstN && imemWe)
            imem[imemAddr] <= imemData;
    end

    // ------------------------------
    // PC and IF/ID
    // ------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc        <= '0;
            ifIdInstr <= '0;  // Bubble
            ifIdPc    <= '0;
        end else begin
            if (redirect)
                pc <= redirectPc;     // Redirect wins over a stall
            else if (pcWrite)
                pc <= pc + 32'd4;

            if (redirect) begin
                ifIdInstr <= '0;      // Squash the wrong-path fetch
                ifIdPc    <= '0;
            end else if (ifIdWrite) begin
                ifIdInstr <= imem[pc[9:2]];
                ifIdPc    <= pc;
            end
        end
    end

endmodule

// File: hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPkg::opcodeT  idOpcode,
    input  mipsPkg::functT   idFunct,
    input  mipsPkg::regAddrT idRs,
    input  mipsPkg::regAddrT idRt,
    input  mipsPkg::regAddrT exDstReg,
    input  logic             exRegWrite,
    input  logic             exMemRead,
    input  mipsPkg::regAddrT memDstReg,
    input  logic             memMemRead,
    output logic             pcWrite,
    output logic             ifIdWrite,
    output logic             idBubble
);
    import mipsPkg::*;

    logic isBranch;
    logic isJr;
    logic exHitRs;   // EX destination matches a decode source
    logic exHitRt;
    logic memHitRs;  // MEM load target matches a decode source
    logic memHitRt;
    logic stall;

    assign isBranch = (idOpcode == OP_BEQ) || (idOpcode == OP_BNE);
    assign isJr     = (idOpcode == OP_RTYPE) && (idFunct == FN_JR);

    // r0 never carries a dependence
    assign exHitRs  = (exDstReg != '0) && (exDstReg == idRs);
    assign exHitRt  = (exDstReg != '0) && (exDstReg == idRt);
    assign memHitRs = memMemRead && (memDstReg != '0) && (memDstReg == idRs);
    assign memHitRt = memMemRead && (memDstReg != '0) && (memDstReg == idRt);

    // ------------------------------
    // Stall detection, by priority
    // ------------------------------
    always_comb begin
        if (isBranch && exRegWrite && (exHitRs || exHitRt))
            stall = 1'b1;   // Compare needs a value still in EX
        else if (isJr && exRegWrite && exHitRs)
            stall = 1'b1;   // Same for the jump register
        else if (isBranch && (memHitRs || memHitRt))
            stall = 1'b1;   // Load data not ready until writeback
        else if (isJr && memHitRs)
            stall = 1'b1;
        else if (exMemRead && (exHitRs || exHitRt))
            stall = 1'b1;   // Classic load-use
        else
            stall = 1'b0;
    end

    // Hold PC and IF/ID, send a bubble down to EX
    assign pcWrite   = !stall;
    assign ifIdWrite = !stall;
    assign idBubble  = stall;

endmodule

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::regAddrT memDstReg,
    input  logic             memRegWrite,
    input  logic             memMemRead,
    input  logic             memMemWrite,
    input  mipsPkg::wordT    memAluResult,
    input  mipsPkg::wordT    memStoreData,
    output logic             storeValid,
    output mipsPkg::wordT    storeAddr,
    output mipsPkg::wordT    storeData,
    output logic             wbRegWrite,
    output mipsPkg::regAddrT wbDstReg,
    output mipsPkg::wordT    wbData
);
    import mipsPkg::*;

    wordT dmem [DMEM_DEPTH];   // Word addressed

    // ------------------------------
    // Data array and store strobe
    // ------------------------------
    always_ff @(posedge clk) begin
        if (memMemWrite)
            dmem[memAluResult[9:2]] <= memStoreData;
        storeAddr <= memAluResult;
        storeData <= memStoreData;
        wbData    <= memMemRead ? dmem[memAluResult[9:2]] : memAluResult;   // Writeback select
    end

    // MEM/WB control
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            storeValid <= 1'b0;
            wbRegWrite <= 1'b0;
            wbDstReg   <= '0;
        end else begin
            storeValid <= memMemWrite;   // One pulse per SW
            wbRegWrite <= memRegWrite;
            wbDstReg   <= memDstReg;
        end
    end

endmodule

// File: mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic          clk,
    input  logic          arstN,
    input  logic          imemWe,
    input  logic [7:0]    imemAddr,
    input  mipsPkg::wordT imemData,
    output logic          storeValid,
    output mipsPkg::wordT storeAddr,
    output mipsPkg::wordT storeData
);
    import mipsPkg::*;

    // Fetch and hazard control
    wordT    ifIdInstr, ifIdPc, redirectPc;
    logic    redirect, pcWrite, ifIdWrite, idBubble;
    opcodeT  idOpcode;
    functT   idFunct;
    regAddrT idRs, idRt;

    // ------------------------------
    // ID/EX, EX/MEM and MEM/WB
    // ------------------------------
    regAddrT exRs, exRt, exDstReg;
    logic    exRegWrite, exMemRead, exMemWrite, exAluSrcImm, exLink;
    aluOpT   exAluOp;
    wordT    exA, exB, exImm, exLinkAddr;
    regAddrT memDstReg;
    logic    memRegWrite, memMemRead, memMemWrite;
    wordT    memAluResult, memStoreData;
    regAddrT wbDstReg;
    logic    wbRegWrite;
    wordT    wbData;

    fetchStage uFetch (.*);

    hazardUnit uHazard (.*);

    decodeStage uDecode (.*);

    executeStage uExecute (.*);

    memoryStage uMemory (.*);

endmodule

// File: mipsPkg.sv
package mipsPkg;

    // ------------------------------
    // Widths and basic types
    // ------------------------------
    localparam int WORD_W = 32;
    localparam int REG_AW = 5;

    typedef logic [WORD_W-1:0] wordT;     // Data and instruction word
    typedef logic [REG_AW-1:0] regAddrT;  // Register number
    typedef logic [5:0]        opcodeT;
    typedef logic [5:0]        functT;
    typedef logic [1:0]        regDstT;   // Destination field select
    typedef logic [2:0]        aluOpT;

    // Primary opcodes
    localparam opcodeT OP_RTYPE = 6'b000000;
    localparam opcodeT OP_J     = 6'b000010;
    localparam opcodeT OP_JAL   = 6'b000011;
    localparam opcodeT OP_BEQ   = 6'b000100;
    localparam opcodeT OP_BNE   = 6'b000101;
    localparam opcodeT OP_ADDI  = 6'b001000;
    localparam opcodeT OP_ORI   = 6'b001101;
    localparam opcodeT OP_LUI   = 6'b001111;
    localparam opcodeT OP_LW    = 6'b100011;
    localparam opcodeT OP_SW    = 6'b101011;

    // R-type function codes
    localparam functT FN_JR   = 6'b001000;
    localparam functT FN_ADDU = 6'b100001;
    localparam functT FN_SUBU = 6'b100011;
    localparam functT FN_AND  = 6'b100100;
    localparam functT FN_OR   = 6'b100101;
    localparam functT FN_SLT  = 6'b101010;

    localparam regDstT REG_DST_RT = 2'b00;
    localparam regDstT REG_DST_RD = 2'b01;
    localparam regDstT REG_DST_RA = 2'b10;  // JAL link register

    // ALU operations
    localparam aluOpT ALU_ADD = 3'd0;
    localparam aluOpT ALU_SUB = 3'd1;
    localparam aluOpT ALU_AND = 3'd2;
    localparam aluOpT ALU_OR  = 3'd3;
    localparam aluOpT ALU_SLT = 3'd4;
    localparam aluOpT ALU_LUI = 3'd5;   // Immediate into upper half

    localparam int IMEM_DEPTH = 256;    // Words
    localparam int DMEM_DEPTH = 256;

endpackage

// File: tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore;
    import mipsPkg::*;

    localparam int   MARKER_ADDR = 'h3FC;   // End-of-program store address
    localparam int   RAND_BASE   = 'h500;   // Scratch area of the random programs
    localparam int   RAND_LEN    = 60;
    localparam int   MARGIN      = 200;     // Extra cycles for reset and pipeline drain
    localparam wordT HALT        = {OP_BEQ, 10'd0, 16'hFFFF};   // Branch to itself

    logic clk;
    logic arstN;
    logic imemWe;
    logic [7:0] imemAddr;
    wordT imemData;
    logic storeValid;
    wordT storeAddr, storeData;

    wordT lfsr;
    wordT prog [$];       // Program under construction
    wordT expAddr [$];    // Expected store stream
    wordT expData [$];
    int   errorCount, testsRun, testsFailed, instrTotal;

    mipsCore DUT (
        .clk        (clk),
        .arstN      (arstN),
        .imemWe     (imemWe),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // ------------------------------
    // Encoders and helpers
    // ------------------------------
    function automatic wordT rOp(functT fn, int rd, int rs, int rt);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic wordT iOp(opcodeT op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic wordT swOp(int rt, int addr);
        return iOp(OP_SW, rt, 0, addr);   // Base is always r0
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic wordT randBits(input int n);
        wordT r;
        logic fb;
        r = '0;
        repeat (n) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic checkEqual(input wordT actual, input wordT expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    task automatic expectStore(input wordT addr, input wordT data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic storeExpect(input int rt, input int addr, input wordT data);
        prog.push_back(swOp(rt, addr));
        expectStore(addr, data);
    endtask

    // ------------------------------
    // Load, run and compare stores
    // ------------------------------
    task automatic runProgram(input string name);
        int   errorsBefore;
        int   resetCycles;
        int   i;
        bit   markerSeen;
        wordT gotAddr [$];
        wordT gotData [$];
        errorsBefore = errorCount;
        prog.push_back(swOp(0, MARKER_ADDR));
        prog.push_back(HALT);
        instrTotal += prog.size();
        resetCycles = (prog.size() < 10) ? 10 : prog.size() + 1;
        @(posedge clk);
        arstN <= 1'b0;
        for (i = 0; i < resetCycles; i++) begin   // Loader writes only during reset
            imemWe   <= (i < prog.size());
            imemAddr <= 8'(i);
            imemData <= (i < prog.size()) ? prog[i] : '0;
            @(posedge clk);
        end
        imemWe <= 1'b0;
        arstN  <= 1'b1;
        markerSeen = 1'b0;
        while (!markerSeen) begin
            @(negedge clk);   // Registered strobe is stable here
            if (storeValid) begin
                if (storeAddr == MARKER_ADDR)
                    markerSeen = 1'b1;
                else begin
                    gotAddr.push_back(storeAddr);
                    gotData.push_back(storeData);
                end
            end
        end
        for (i = 0; i < expAddr.size(); i++) begin
            if (i >= gotAddr.size()) begin
                $display("%s: store %0d to address %h never appeared", name, i, expAddr[i]);
                errorCount++;
            end else begin
                checkEqual(gotAddr[i], expAddr[i], $sformatf("%s store %0d address", name, i));
                checkEqual(gotData[i], expData[i], $sformatf("%s store %0d data", name, i));
            end
        end
        if (gotAddr.size() > expAddr.size()) begin
            $display("%s: %0d more stores appeared than the program makes",
                     name, gotAddr.size() - expAddr.size());
            errorCount++;
        end
        testsRun++;
        if (errorCount != errorsBefore)
            testsFailed++;
        $display("Test %s: %s, %0d stores seen", name,
                 (errorCount == errorsBefore) ? "ok" : "failed", gotAddr.size());
        prog.delete();
        expAddr.delete();
        expData.delete();
    endtask

    // Sequential ALU and memory reference for the random programs
    task automatic modelProgram();
        wordT    regs [32];
        wordT    mem [wordT];
        wordT    ins, a, b, sImm;
        regAddrT rs, rt, rd;
        foreach (regs[r])
            regs[r] = '0;
        foreach (prog[i]) begin
            ins  = prog[i];
            rs   = ins[25:21];
            rt   = ins[20:16];
            rd   = ins[15:11];
            a    = regs[rs];
            b    = regs[rt];
            sImm = {{16{ins[15]}}, ins[15:0]};
            case (ins[31:26])
                OP_RTYPE: begin
                    case (ins[5:0])
                        FN_ADDU: regs[rd] = a + b;
                        FN_SUBU: regs[rd] = a - b;
                        FN_AND:  regs[rd] = a & b;
                        FN_OR:   regs[rd] = a | b;
                        FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                OP_ADDI: regs[rt] = a + sImm;
                OP_ORI:  regs[rt] = a | {16'h0, ins[15:0]};
                OP_LUI:  regs[rt] = {ins[15:0], 16'h0};
                OP_LW:   regs[rt] = mem[a + sImm];
                OP_SW: begin
                    mem[a + sImm] = b;
                    expectStore(a + sImm, b);
                end
                default: ;
            endcase
            regs[0] = '0;   // r0 stays zero
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic aluChainTest();
        prog.push_back(iOp(OP_ADDI, 1, 0, 12));
        prog.push_back(iOp(OP_ADDI, 2, 1, -5));   // r1 still in MEM
        storeExpect(2, 'h100, 32'd7);
        prog.push_back(rOp(FN_ADDU, 3, 1, 2));
        storeExpect(3, 'h104, 32'd19);
        prog.push_back(rOp(FN_SUBU, 4, 2, 3));
        storeExpect(4, 'h108, 32'hFFFF_FFF4);     // 7 - 19
        prog.push_back(rOp(FN_AND, 5, 4, 3));
        storeExpect(5, 'h10C, 32'h10);
        prog.push_back(rOp(FN_OR, 6, 5, 2));
        storeExpect(6, 'h110, 32'h17);
        prog.push_back(rOp(FN_SLT, 7, 4, 1));     // Signed compare -12 < 12
        storeExpect(7, 'h114, 32'd1);
        prog.push_back(rOp(FN_SLT, 8, 1, 4));
        storeExpect(8, 'h118, 32'd0);
        prog.push_back(iOp(OP_LUI, 9, 0, 'h1234));
        prog.push_back(iOp(OP_ORI, 9, 9, 'h5678));
        storeExpect(9, 'h11C, 32'h1234_5678);
        prog.push_back(rOp(FN_ADDU, 0, 1, 1));    // Write to r0 dropped
        storeExpect(0, 'h120, 32'd0);
        runProgram("aluChain");
    endtask

    task automatic loadUseTest();
        prog.push_back(iOp(OP_ORI, 1, 0, 'hAB));
        storeExpect(1, 'h200, 32'hAB);
        prog.push_back(iOp(OP_ADDI, 2, 0, 100));
        prog.push_back(iOp(OP_LW, 3, 0, 'h200));
        prog.push_back(rOp(FN_ADDU, 4, 3, 2));    // Needs one stall
        storeExpect(4, 'h204, 32'h10F);
        prog.push_back(iOp(OP_LW, 5, 0, 'h200));
        storeExpect(5, 'h208, 32'hAB);            // Loaded value as store data
        prog.push_back(iOp(OP_LW, 6, 0, 'h204));
        prog.push_back(iOp(OP_ADDI, 7, 6, 1));
        storeExpect(7, 'h20C, 32'h110);
        runProgram("loadUse");
    endtask

    task automatic branchTest();
        prog.push_back(iOp(OP_ADDI, 3, 0, 7));     // Old r3 equals r1
        prog.push_back(iOp(OP_ADDI, 1, 0, 7));
        prog.push_back(iOp(OP_ADDI, 2, 0, 7));
        prog.push_back(iOp(OP_BEQ, 2, 1, 1));     // Taken on a just written r2
        prog.push_back(swOp(1, 'h300));           // Squashed slot
        storeExpect(1, 'h304, 32'd7);
        prog.push_back(iOp(OP_ADDI, 3, 0, 9));
        prog.push_back(iOp(OP_BEQ, 3, 1, 1));     // Not taken only with the new r3
        storeExpect(3, 'h308, 32'd9);
        prog.push_back(iOp(OP_BNE, 3, 1, 1));     // Taken
        prog.push_back(swOp(0, 'h30C));
        prog.push_back(iOp(OP_LW, 4, 0, 'h304));
        prog.push_back(iOp(OP_BNE, 1, 4, 1));     // Not taken on a just loaded r4
        storeExpect(4, 'h310, 32'd7);
        prog.push_back(iOp(OP_LW, 5, 0, 'h308));
        prog.push_back(iOp(OP_BEQ, 3, 5, 1));     // Taken on loaded value
        prog.push_back(swOp(0, 'h314));
        storeExpect(5, 'h318, 32'd9);
        runProgram("branch");
    endtask

    task automatic jumpLinkTest();
        prog.push_back(iOp(OP_ADDI, 2, 0, 'h55));  // 0
        prog.push_back({OP_JAL, 26'd6});           // 1 with link 8
        prog.push_back(swOp(2, 'h404));            // 2 is the return point
        prog.push_back(iOp(OP_ORI, 8, 0, 40));     // 3
        prog.push_back(rOp(FN_JR, 0, 8, 0));       // 4 with r8 just written
        prog.push_back(swOp(0, 'h408));            // 5 is squashed
        prog.push_back(swOp(31, 'h400));           // 6 starts the routine
        prog.push_back(iOp(OP_ADDI, 2, 0, 'h66));  // 7
        prog.push_back(rOp(FN_JR, 0, 31, 0));      // 8
        prog.push_back(swOp(0, 'h40C));            // 9 is squashed
        prog.push_back(swOp(8, 'h410));            // 10
        expectStore('h400, 32'd8);
        expectStore('h404, 32'h66);
        expectStore('h410, 32'd40);
        runProgram("jumpLink");
    endtask

    task automatic randomTest();
        int k;
        int sel, rd, rs, rt, imm;
        for (k = 1; k < 8; k++)
            prog.push_back(iOp(OP_ORI, k, 0, int'(randBits(16))));
        for (k = 0; k < 8; k++)
            prog.push_back(swOp(k % 7 + 1, RAND_BASE + 4 * k));   // Known data before loads
        for (k = 0; k < RAND_LEN; k++) begin
            sel = int'(randBits(4));
            rd  = int'(randBits(3));
            rs  = int'(randBits(3));
            rt  = int'(randBits(3));
            imm = int'(randBits(16));
            case (sel)
                0:       prog.push_back(rOp(FN_ADDU, rd, rs, rt));
                1:       prog.push_back(rOp(FN_SUBU, rd, rs, rt));
                2:       prog.push_back(rOp(FN_AND, rd, rs, rt));
                3:       prog.push_back(rOp(FN_OR, rd, rs, rt));
                4:       prog.push_back(rOp(FN_SLT, rd, rs, rt));
                5:       prog.push_back(iOp(OP_ADDI, rd, rs, imm));
                6:       prog.push_back(iOp(OP_ORI, rd, rs, imm));
                7:       prog.push_back(iOp(OP_LUI, rd, 0, imm));
                8:       prog.push_back(iOp(OP_LW, rd, 0, RAND_BASE + 4 * (imm % 8)));
                default: prog.push_back(swOp(rt, RAND_BASE + 4 * (imm % 8)));
            endcase
        end
        modelProgram();
        runProgram("random");
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        arstN      = 1'b0;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        lfsr       = 32'h684f;
        errorCount = 0;
        testsRun   = 0;
        testsFailed = 0;
        instrTotal = 0;
        aluChainTest();
        loadUseTest();
        branchTest();
        jumpLinkTest();
        randomTest();
        $display("Tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Limit grows with every program loaded
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 4 * instrTotal + MARGIN) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: no end of program after %0d cycles", cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: vlog.f
mipsPkg.sv
fetchStage.sv
hazardUnit.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
mipsCore.sv
tbMipsCore.sv
